// File: alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand and result width
`define ALU_DATA_W      32

// opcode field, matches alu_pkg::alu_op_e
`define ALU_OP_W        6

// bit number for BIT/SET/RES/CHG/TSET, taken from the low source bits
`define ALU_BIT_IDX_W   4

// flag byte layout {S,Z,0,H,0,V,N,C}
`define ALU_FLAG_S      7
`define ALU_FLAG_Z      6
`define ALU_FLAG_H      4
`define ALU_FLAG_V      2   // overflow or parity
`define ALU_FLAG_N      1
`define ALU_FLAG_C      0

`endif

// File: alu_pkg.sv
package alu_pkg;

    typedef logic [31:0] word_t;    // operand or result
    typedef logic [2:0]  width_t;   // one-hot: byte, word, long; zero is idle
    typedef logic [7:0]  flags_t;   // {S,Z,0,H,0,V,N,C}
    typedef logic [3:0]  bit_idx_t; // bit number for single-bit ops

    typedef enum logic [5:0] {
        // moves and arithmetic
        ALU_MOVE = 6'd0,
        ALU_ADD  = 6'd1,
        ALU_ADC  = 6'd2,
        ALU_INC  = 6'd3,
        ALU_SUB  = 6'd4,
        ALU_SBC  = 6'd5,
        ALU_CP   = 6'd6,
        ALU_DEC  = 6'd7,
        ALU_NEG  = 6'd8,
        // logic
        ALU_AND  = 6'd9,
        ALU_OR   = 6'd10,
        ALU_XOR  = 6'd11,
        ALU_CPL  = 6'd12,
        // single bit
        ALU_BIT  = 6'd13,
        ALU_SET  = 6'd14,
        ALU_RES  = 6'd15,
        ALU_CHG  = 6'd16,
        ALU_TSET = 6'd17,
        // carry flag only
        ALU_SCF  = 6'd18,
        ALU_RCF  = 6'd19,
        ALU_CCF  = 6'd20,
        ALU_ZCF  = 6'd21,
        // one-bit shifts and rotates
        ALU_RLC  = 6'd22,
        ALU_RRC  = 6'd23,
        ALU_RL   = 6'd24,
        ALU_RR   = 6'd25,
        ALU_SLA  = 6'd26,
        ALU_SRA  = 6'd27,
        ALU_SLL  = 6'd28,
        ALU_SRL  = 6'd29
    } alu_op_e;

endpackage

// File: alu_unit_if.sv
// result and status of one execution unit
interface alu_unit_if;

    alu_pkg::word_t rslt;
    logic           c;      // carry out at the selected width
    logic           h;      // carry/borrow out of bit 3
    logic           v;      // signed overflow at the selected width
    logic           bit_z;  // inverse of the tested bit

    modport unit (
        output rslt, c, h, v, bit_z
    );

    modport sink (
        input  rslt, c, h, v, bit_z
    );

endinterface

// File: alu_adder.sv
module alu_adder (
    input  alu_pkg::word_t   op0,
    input  alu_pkg::word_t   op2,
    input  alu_pkg::alu_op_e sel,
    input  alu_pkg::width_t  w,
    input  logic             carry,
    alu_unit_if.unit         bus
);

    alu_pkg::word_t a;
    alu_pkg::word_t b;
    alu_pkg::word_t r;
    logic           sub;
    logic           cin;
    logic           hc, c8, c16, c32;   // carries out of bits 3, 7, 15, 31
    logic [32:0]    ext_a, ext_b, ext_r;
    logic           r_top;

    // sign extension to 33 bits at the given width, for the overflow check
    function automatic logic [32:0] extend(input alu_pkg::word_t x, input alu_pkg::width_t wd);
        if (wd[0])
            return {{25{x[7]}}, x[7:0]};
        else if (wd[1])
            return {{17{x[15]}}, x[15:0]};
        else
            return {x[31], x};
    endfunction

    always_comb begin
        a   = op0;
        b   = op2;
        sub = 1'b1;
        cin = 1'b0;
        case (sel)
            alu_pkg::ALU_ADD, alu_pkg::ALU_INC: sub = 1'b0;
            alu_pkg::ALU_ADC: begin
                sub = 1'b0;
                cin = carry;
            end
            alu_pkg::ALU_SBC: cin = carry;
            alu_pkg::ALU_NEG: begin
                a = '0;     // 0 - op0
                b = op0;
            end
            default: ;
        endcase
    end

    assign ext_a = extend(a, w);
    assign ext_b = extend(b, w);

    // chain split at 4/8/16 so every width gets its own carry
    always_comb begin
        if (sub) begin
            {hc,  r[3:0]}   = {1'b0, a[3:0]}   - {1'b0, b[3:0]}   - {4'd0, cin};
            {c8,  r[7:4]}   = {1'b0, a[7:4]}   - {1'b0, b[7:4]}   - {4'd0, hc};
            {c16, r[15:8]}  = {1'b0, a[15:8]}  - {1'b0, b[15:8]}  - {8'd0, c8};
            {c32, r[31:16]} = {1'b0, a[31:16]} - {1'b0, b[31:16]} - {16'd0, c16};
            ext_r = ext_a - ext_b - {32'd0, cin};
        end else begin
            {hc,  r[3:0]}   = {1'b0, a[3:0]}   + {1'b0, b[3:0]}   + {4'd0, cin};
            {c8,  r[7:4]}   = {1'b0, a[7:4]}   + {1'b0, b[7:4]}   + {4'd0, hc};
            {c16, r[15:8]}  = {1'b0, a[15:8]}  + {1'b0, b[15:8]}  + {8'd0, c8};
            {c32, r[31:16]} = {1'b0, a[31:16]} + {1'b0, b[31:16]} + {16'd0, c16};
            ext_r = ext_a + ext_b + {32'd0, cin};
        end
    end

    assign r_top = w[0] ? ext_r[7] : w[1] ? ext_r[15] : ext_r[31];

    assign bus.rslt  = r;
    assign bus.c     = w[0] ? c8 : w[1] ? c16 : c32;
    assign bus.h     = hc;
    assign bus.v     = ext_r[32] ^ r_top;   // true sign vs sign at width
    assign bus.bit_z = 1'b0;

endmodule

// File: alu_logic.sv
module alu_logic (
    input  alu_pkg::word_t   op0,
    input  alu_pkg::word_t   op2,
    input  alu_pkg::alu_op_e sel,
    alu_unit_if.unit         bus
);

    alu_pkg::bit_idx_t idx;
    logic [4:0]        pos;     // index into the 32-bit operand
    alu_pkg::word_t    r;

    assign idx = op2[$bits(alu_pkg::bit_idx_t)-1:0];
    assign pos = {1'b0, idx};

    always_comb begin
        r = op0;
        case (sel)
            alu_pkg::ALU_AND: r = op0 & op2;
            alu_pkg::ALU_OR:  r = op0 | op2;
            alu_pkg::ALU_XOR: r = op0 ^ op2;
            alu_pkg::ALU_CPL: r = ~op2;     // complement of the source

            // tset writes the bit after testing it
            alu_pkg::ALU_SET, alu_pkg::ALU_TSET: begin
                r[pos] = 1'b1;
            end
            alu_pkg::ALU_RES: begin
                r[pos] = 1'b0;
            end
            alu_pkg::ALU_CHG: begin
                r[pos] = ~op0[pos];
            end
            default: ;
        endcase
    end

    assign bus.rslt  = r;
    assign bus.c     = 1'b0;
    assign bus.h     = 1'b0;
    assign bus.v     = 1'b0;
    assign bus.bit_z = ~op0[pos];   // original bit, before any tset

endmodule

// File: alu_shifter.sv
module alu_shifter (
    input  alu_pkg::word_t   op0,
    input  alu_pkg::alu_op_e sel,
    input  alu_pkg::width_t  w,
    input  logic             carry,
    alu_unit_if.unit         bus
);

    logic           left;
    logic           top;        // msb of op0 at the selected width
    logic           lsb_in;
    logic           msb_in;
    alu_pkg::word_t r;

    assign top  = w[0] ? op0[7] : w[1] ? op0[15] : op0[31];
    assign left = sel inside {alu_pkg::ALU_RLC, alu_pkg::ALU_RL,
                              alu_pkg::ALU_SLA, alu_pkg::ALU_SLL};

    // fill bits for the vacated position
    always_comb begin
        case (sel)
            alu_pkg::ALU_RLC: lsb_in = top;
            alu_pkg::ALU_RL:  lsb_in = carry;
            default:          lsb_in = 1'b0;
        endcase
        case (sel)
            alu_pkg::ALU_RRC: msb_in = op0[0];
            alu_pkg::ALU_RR:  msb_in = carry;
            alu_pkg::ALU_SRA: msb_in = top;     // keep sign
            default:          msb_in = 1'b0;
        endcase
    end

    // upper bits above the width pass through
    always_comb begin
        r = op0;
        if (left) begin
            if (w[0])
                r[7:0] = {op0[6:0], lsb_in};
            else if (w[1])
                r[15:0] = {op0[14:0], lsb_in};
            else
                r = {op0[30:0], lsb_in};
        end else begin
            if (w[0])
                r[7:0] = {msb_in, op0[7:1]};
            else if (w[1])
                r[15:0] = {msb_in, op0[15:1]};
            else
                r = {msb_in, op0[31:1]};
        end
    end

    assign bus.rslt  = r;
    assign bus.c     = left ? top : op0[0];     // bit shifted out
    assign bus.h     = 1'b0;
    assign bus.v     = 1'b0;
    assign bus.bit_z = 1'b0;

endmodule

// File: alu_writeback.sv
`include "alu_config.svh"

module alu_writeback (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  alu_pkg::alu_op_e sel,
    input  alu_pkg::width_t  w,
    input  alu_pkg::word_t   op2,
    alu_unit_if.sink         add_bus,
    alu_unit_if.sink         log_bus,
    alu_unit_if.sink         shf_bus,
    output alu_pkg::word_t   dout,
    output alu_pkg::flags_t  flags,
    output alu_pkg::width_t  alu_we,
    output logic             carry
);

    alu_pkg::word_t  rslt;
    alu_pkg::flags_t nx_flags;
    logic            rslt_s, is_zero, rslt_even;
    logic            nx_s, nx_z, nx_h, nx_v, nx_n, nx_c;

    always_comb begin
        case (sel)
            alu_pkg::ALU_MOVE: rslt = op2;
            alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_INC,
            alu_pkg::ALU_SUB, alu_pkg::ALU_SBC, alu_pkg::ALU_CP,
            alu_pkg::ALU_DEC, alu_pkg::ALU_NEG: rslt = add_bus.rslt;
            alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR,
            alu_pkg::ALU_CPL, alu_pkg::ALU_SET, alu_pkg::ALU_RES,
            alu_pkg::ALU_CHG, alu_pkg::ALU_TSET: rslt = log_bus.rslt;
            alu_pkg::ALU_RLC, alu_pkg::ALU_RRC, alu_pkg::ALU_RL,
            alu_pkg::ALU_RR, alu_pkg::ALU_SLA, alu_pkg::ALU_SRA,
            alu_pkg::ALU_SLL, alu_pkg::ALU_SRL: rslt = shf_bus.rslt;
            default: rslt = dout;   // bit test and carry ops
        endcase
    end

    assign rslt_s    = w[0] ? rslt[7] : w[1] ? rslt[15] : rslt[`ALU_DATA_W-1];
    assign is_zero   = w[0] ? rslt[7:0] == '0 :
                       w[1] ? rslt[15:0] == '0 : rslt[`ALU_DATA_W-1:0] == '0;
    assign rslt_even = w[0] ? ~^rslt[7:0] : ~^rslt[15:0];

    always_comb begin
        nx_s = flags[`ALU_FLAG_S];
        nx_z = flags[`ALU_FLAG_Z];
        nx_h = flags[`ALU_FLAG_H];
        nx_v = flags[`ALU_FLAG_V];
        nx_n = flags[`ALU_FLAG_N];
        nx_c = flags[`ALU_FLAG_C];
        case (sel)
            alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_SUB,
            alu_pkg::ALU_SBC, alu_pkg::ALU_CP, alu_pkg::ALU_NEG: begin
                nx_s = rslt_s;
                nx_z = is_zero;
                nx_h = add_bus.h;
                nx_v = add_bus.v;
                nx_c = add_bus.c;
                nx_n = sel != alu_pkg::ALU_ADD && sel != alu_pkg::ALU_ADC;
            end
            alu_pkg::ALU_INC, alu_pkg::ALU_DEC: begin
                if (w[0]) begin     // wider inc/dec leave flags alone
                    nx_s = rslt_s;
                    nx_z = is_zero;
                    nx_h = add_bus.h;
                    nx_v = add_bus.v;
                    nx_n = sel == alu_pkg::ALU_DEC;
                end
            end
            alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR: begin
                nx_s = rslt_s;
                nx_z = is_zero;
                nx_h = sel == alu_pkg::ALU_AND;
                nx_v = rslt_even;
                nx_n = 1'b0;
                nx_c = 1'b0;
            end
            alu_pkg::ALU_CPL: begin
                nx_h = 1'b1;
                nx_n = 1'b1;
            end
            alu_pkg::ALU_RLC, alu_pkg::ALU_RRC, alu_pkg::ALU_RL,
            alu_pkg::ALU_RR, alu_pkg::ALU_SLA, alu_pkg::ALU_SRA,
            alu_pkg::ALU_SLL, alu_pkg::ALU_SRL: begin
                nx_s = rslt_s;
                nx_z = is_zero;
                nx_h = 1'b0;
                nx_v = rslt_even;
                nx_n = 1'b0;
                nx_c = shf_bus.c;
            end
            alu_pkg::ALU_BIT, alu_pkg::ALU_TSET: begin
                nx_z = log_bus.bit_z;
                nx_h = 1'b1;
                nx_n = 1'b0;
            end
            alu_pkg::ALU_SCF, alu_pkg::ALU_RCF: begin
                nx_c = sel == alu_pkg::ALU_SCF;
                nx_h = 1'b0;
                nx_n = 1'b0;
            end
            alu_pkg::ALU_CCF: begin
                nx_c = ~flags[`ALU_FLAG_C];
                nx_n = 1'b0;
            end
            alu_pkg::ALU_ZCF: begin
                nx_c = ~flags[`ALU_FLAG_Z];
                nx_n = 1'b0;
            end
            default: ;  // move, set, res, chg
        endcase
    end

    always_comb begin
        nx_flags              = '0;     // bits 5 and 3 read zero
        nx_flags[`ALU_FLAG_S] = nx_s;
        nx_flags[`ALU_FLAG_Z] = nx_z;
        nx_flags[`ALU_FLAG_H] = nx_h;
        nx_flags[`ALU_FLAG_V] = nx_v;
        nx_flags[`ALU_FLAG_N] = nx_n;
        nx_flags[`ALU_FLAG_C] = nx_c;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            flags  <= '0;
            alu_we <= '0;
        end else if (cen) begin
            alu_we <= w;
            if (w != '0) begin
                dout  <= rslt;
                flags <= nx_flags;
            end
        end
    end

    assign carry = flags[`ALU_FLAG_C];

endmodule

// File: alu_top.sv
`include "alu_config.svh"

module alu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  alu_pkg::word_t   op0,       // destination
    input  alu_pkg::word_t   op1,       // register source
    input  alu_pkg::word_t   imm,       // immediate source
    input  logic             sel_imm,
    input  alu_pkg::alu_op_e sel,
    input  alu_pkg::width_t  w,
    output alu_pkg::word_t   dout,
    output alu_pkg::flags_t  flags,
    output alu_pkg::width_t  alu_we
);

    logic [`ALU_DATA_W-1:0] op2;
    logic                   carry;      // registered C flag

    alu_unit_if add_bus ();
    alu_unit_if log_bus ();
    alu_unit_if shf_bus ();

    assign op2 = sel_imm ? imm : op1;

    alu_adder u_adder (
        .op0   (op0),
        .op2   (op2),
        .sel   (sel),
        .w     (w),
        .carry (carry),
        .bus   (add_bus.unit)
    );

    alu_logic u_logic (
        .op0 (op0),
        .op2 (op2),
        .sel (sel),
        .bus (log_bus.unit)
    );

    alu_shifter u_shifter (
        .op0   (op0),
        .sel   (sel),
        .w     (w),
        .carry (carry),
        .bus   (shf_bus.unit)
    );

    alu_writeback u_writeback (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .sel     (sel),
        .w       (w),
        .op2     (op2),
        .add_bus (add_bus.sink),
        .log_bus (log_bus.sink),
        .shf_bus (shf_bus.sink),
        .dout    (dout),
        .flags   (flags),
        .alu_we  (alu_we),
        .carry   (carry)
    );

endmodule

// File: tb_alu.sv
`include "alu_config.svh"

module tb_alu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS     = 4;
    localparam int RST_CYCLES = 16;

    localparam alu_pkg::width_t W_IDLE = 3'b000;
    localparam alu_pkg::width_t W_B    = 3'b001;
    localparam alu_pkg::width_t W_W    = 3'b010;
    localparam alu_pkg::width_t W_L    = 3'b100;

    // one table row; fixed rows carry their own operands and expected dout
    typedef struct {
        alu_pkg::alu_op_e op;
        alu_pkg::width_t  w;
        logic             sel_imm;
        logic             cen;
        logic             fixed;
        alu_pkg::word_t   op0;
        alu_pkg::word_t   op1;
        alu_pkg::word_t   imm;
        alu_pkg::word_t   exp;
    } row_t;

    logic             clk;
    logic             rst;
    logic             cen;
    alu_pkg::word_t   op0;
    alu_pkg::word_t   op1;
    alu_pkg::word_t   imm;
    logic             sel_imm;
    alu_pkg::alu_op_e sel;
    alu_pkg::width_t  w;
    alu_pkg::word_t   dout;
    alu_pkg::flags_t  flags;
    alu_pkg::width_t  alu_we;

    row_t            rows[$];
    logic            table_done;
    logic [31:0]     lcg_state;
    int              cur_row;
    alu_pkg::word_t  ref_dout;
    alu_pkg::word_t  ref_mask;      // bits of ref_dout that are defined
    alu_pkg::flags_t ref_flags;
    alu_pkg::width_t ref_we;

    alu_top UUT (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .op0     (op0),
        .op1     (op1),
        .imm     (imm),
        .sel_imm (sel_imm),
        .sel     (sel),
        .w       (w),
        .dout    (dout),
        .flags   (flags),
        .alu_we  (alu_we)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic alu_pkg::word_t rand_word();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi = lcg_state[31:16];  // low lcg bits are weak
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic alu_pkg::word_t width_mask(input alu_pkg::width_t wd);
        return wd[0] ? 32'h0000_00ff : wd[1] ? 32'h0000_ffff : 32'hffff_ffff;
    endfunction

    function automatic logic msb_at(input alu_pkg::word_t x, input alu_pkg::width_t wd);
        return wd[0] ? x[7] : wd[1] ? x[15] : x[31];
    endfunction

    function automatic logic carry_at(input logic [32:0] f, input alu_pkg::width_t wd);
        return wd[0] ? f[8] : wd[1] ? f[16] : f[32];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input alu_pkg::word_t got,
                              input alu_pkg::word_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH row %0d %s got 0x%h expected 0x%h",
                               cur_row, name, got, exp));
    endtask

    task automatic check_flags(input string name, input alu_pkg::flags_t got,
                               input alu_pkg::flags_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH row %0d %s got 0x%h expected 0x%h",
                               cur_row, name, got, exp));
    endtask

    task automatic check_width(input string name, input alu_pkg::width_t got,
                               input alu_pkg::width_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH row %0d %s got 0x%h expected 0x%h",
                               cur_row, name, got, exp));
    endtask

    // reference model of one enabled operation
    task automatic apply_model(input alu_pkg::alu_op_e op, input alu_pkg::width_t wd,
                               input alu_pkg::word_t a, input alu_pkg::word_t b);
        alu_pkg::word_t  m;
        alu_pkg::word_t  am;
        alu_pkg::word_t  bm;
        alu_pkg::word_t  r;
        alu_pkg::flags_t fl;
        logic [32:0]     full;
        logic [4:0]      hs;
        logic [4:0]      idx;
        logic            cin;
        logic            fill;
        logic            sc;
        logic            keep;   // dout not written
        m    = width_mask(wd);
        am   = a & m;
        bm   = b & m;
        r    = a;
        fl   = ref_flags;
        idx  = {1'b0, b[3:0]};
        cin  = 1'b0;
        fill = 1'b0;
        sc   = 1'b0;
        keep = 1'b0;
        case (op)
            alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_INC: begin
                if (op == alu_pkg::ALU_ADC)
                    cin = ref_flags[`ALU_FLAG_C];
                full = {1'b0, am} + {1'b0, bm} + {32'd0, cin};
                hs   = {1'b0, am[3:0]} + {1'b0, bm[3:0]} + {4'd0, cin};
                r    = full[31:0] & m;
                if (op != alu_pkg::ALU_INC || wd[0]) begin
                    fl[`ALU_FLAG_S] = msb_at(r, wd);
                    fl[`ALU_FLAG_Z] = r == '0;
                    fl[`ALU_FLAG_H] = hs[4];
                    fl[`ALU_FLAG_V] = (msb_at(am, wd) == msb_at(bm, wd)) &&
                                      (msb_at(r, wd) != msb_at(am, wd));
                    fl[`ALU_FLAG_N] = 1'b0;
                end
                if (op != alu_pkg::ALU_INC)
                    fl[`ALU_FLAG_C] = carry_at(full, wd);
            end
            alu_pkg::ALU_SUB, alu_pkg::ALU_SBC, alu_pkg::ALU_CP,
            alu_pkg::ALU_DEC, alu_pkg::ALU_NEG: begin
                if (op == alu_pkg::ALU_NEG) begin
                    bm = am;
                    am = '0;
                end
                if (op == alu_pkg::ALU_SBC)
                    cin = ref_flags[`ALU_FLAG_C];
                full = {1'b0, am} - {1'b0, bm} - {32'd0, cin};
                hs   = {1'b0, am[3:0]} - {1'b0, bm[3:0]} - {4'd0, cin};
                r    = full[31:0] & m;
                if (op != alu_pkg::ALU_DEC || wd[0]) begin
                    fl[`ALU_FLAG_S] = msb_at(r, wd);
                    fl[`ALU_FLAG_Z] = r == '0;
                    fl[`ALU_FLAG_H] = hs[4];   // borrow out of bit 3
                    fl[`ALU_FLAG_V] = (msb_at(am, wd) != msb_at(bm, wd)) &&
                                      (msb_at(r, wd) != msb_at(am, wd));
                    fl[`ALU_FLAG_N] = 1'b1;
                end
                if (op != alu_pkg::ALU_DEC)
                    fl[`ALU_FLAG_C] = carry_at(full, wd);
            end
            alu_pkg::ALU_AND: r = a & b;
            alu_pkg::ALU_OR:  r = a | b;
            alu_pkg::ALU_XOR: r = a ^ b;
            alu_pkg::ALU_CPL: begin
                r = ~b;
                fl[`ALU_FLAG_H] = 1'b1;
                fl[`ALU_FLAG_N] = 1'b1;
            end
            alu_pkg::ALU_BIT, alu_pkg::ALU_TSET: begin
                keep = op == alu_pkg::ALU_BIT;
                r[idx] = 1'b1;
                fl[`ALU_FLAG_Z] = ~a[idx];
                fl[`ALU_FLAG_H] = 1'b1;
                fl[`ALU_FLAG_N] = 1'b0;
            end
            alu_pkg::ALU_SET: r[idx] = 1'b1;
            alu_pkg::ALU_RES: r[idx] = 1'b0;
            alu_pkg::ALU_CHG: r[idx] = ~a[idx];
            alu_pkg::ALU_SCF, alu_pkg::ALU_RCF: begin
                keep = 1'b1;
                fl[`ALU_FLAG_C] = op == alu_pkg::ALU_SCF;
                fl[`ALU_FLAG_H] = 1'b0;
                fl[`ALU_FLAG_N] = 1'b0;
            end
            alu_pkg::ALU_CCF, alu_pkg::ALU_ZCF: begin
                keep = 1'b1;
                fl[`ALU_FLAG_C] = (op == alu_pkg::ALU_CCF) ? ~ref_flags[`ALU_FLAG_C]
                                                           : ~ref_flags[`ALU_FLAG_Z];
                fl[`ALU_FLAG_N] = 1'b0;
            end
            alu_pkg::ALU_RLC, alu_pkg::ALU_RL, alu_pkg::ALU_SLA, alu_pkg::ALU_SLL: begin
                sc = msb_at(a, wd);
                if (op == alu_pkg::ALU_RLC)
                    fill = sc;
                else if (op == alu_pkg::ALU_RL)
                    fill = ref_flags[`ALU_FLAG_C];
                r = ((a << 1) & m) | (a & ~m) | {31'd0, fill};
            end
            alu_pkg::ALU_RRC, alu_pkg::ALU_RR, alu_pkg::ALU_SRA, alu_pkg::ALU_SRL: begin
                sc = a[0];
                if (op == alu_pkg::ALU_RRC)
                    fill = a[0];
                else if (op == alu_pkg::ALU_RR)
                    fill = ref_flags[`ALU_FLAG_C];
                else if (op == alu_pkg::ALU_SRA)
                    fill = msb_at(a, wd);
                r = ((a & m) >> 1) | (a & ~m) | (fill ? (m ^ (m >> 1)) : 32'd0);
            end
            default: r = b;     // move
        endcase
        // logic and shift ops share the parity flag rules
        if (op inside {alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR} ||
            (op >= alu_pkg::ALU_RLC && op <= alu_pkg::ALU_SRL)) begin
            fl[`ALU_FLAG_S] = msb_at(r, wd);
            fl[`ALU_FLAG_Z] = (r & m) == '0;
            fl[`ALU_FLAG_V] = wd[0] ? ~^r[7:0] : ~^r[15:0];
            fl[`ALU_FLAG_H] = op == alu_pkg::ALU_AND;
            fl[`ALU_FLAG_N] = 1'b0;
            fl[`ALU_FLAG_C] = sc;
        end
        if (!keep) begin
            ref_dout = r;
            ref_mask = m;
        end
        ref_flags = fl;
    endtask

    task automatic add_row(input alu_pkg::alu_op_e op, input alu_pkg::width_t wd,
                           input logic si, input logic en, input logic fixed,
                           input alu_pkg::word_t a, input alu_pkg::word_t b,
                           input alu_pkg::word_t exp);
        row_t t;
        t.op      = op;
        t.w       = wd;
        t.sel_imm = si;
        t.cen     = en;
        t.fixed   = fixed;
        t.op0     = a;
        t.op1     = si ? ~b : b;    // unused source differs from the used one
        t.imm     = si ? b : ~b;
        t.exp     = exp;
        rows.push_back(t);
    endtask

    task automatic add_widths(input alu_pkg::alu_op_e op);
        for (int j = 0; j < 3; j++)
            add_row(op, 3'b001 << j, j[0], 1'b1, 1'b0, '0, '0, '0);
    endtask

    task automatic build_table();
        // boundary cases with known results
        add_row(alu_pkg::ALU_ADD, W_B, 1'b1, 1'b1, 1'b1, 32'h7f, 32'h1, 32'h80);
        add_row(alu_pkg::ALU_ADD, W_W, 1'b0, 1'b1, 1'b1, 32'hffff, 32'h1, 32'h0);
        add_row(alu_pkg::ALU_SUB, W_L, 1'b1, 1'b1, 1'b1, 32'h0, 32'h1, 32'hffff_ffff);
        add_row(alu_pkg::ALU_INC, W_B, 1'b1, 1'b1, 1'b1, 32'h7f, 32'h1, 32'h80);
        add_row(alu_pkg::ALU_DEC, W_B, 1'b1, 1'b1, 1'b1, 32'h0, 32'h1, 32'hff);
        add_row(alu_pkg::ALU_INC, W_L, 1'b1, 1'b1, 1'b1, 32'hffff_ffff, 32'h1, 32'h0);
        add_row(alu_pkg::ALU_DEC, W_L, 1'b0, 1'b1, 1'b1, 32'h0, 32'h1, 32'hffff_ffff);
        add_row(alu_pkg::ALU_NEG, W_B, 1'b0, 1'b1, 1'b1, 32'h80, 32'h0, 32'h80);
        add_row(alu_pkg::ALU_CP, W_B, 1'b1, 1'b1, 1'b1, 32'h55, 32'h55, 32'h0);
        add_row(alu_pkg::ALU_ZCF, W_B, 1'b0, 1'b1, 1'b0, '0, '0, '0);  // z set by cp
        add_row(alu_pkg::ALU_CCF, W_B, 1'b0, 1'b1, 1'b0, '0, '0, '0);
        add_row(alu_pkg::ALU_MOVE, W_L, 1'b1, 1'b1, 1'b1, '0, 32'h1234_5678, 32'h1234_5678);
        for (int k = int'(alu_pkg::ALU_ADD); k <= int'(alu_pkg::ALU_SRL); k++)
            add_widths(alu_pkg::alu_op_e'(k));
        // rotates through carry checked in order
        add_widths(alu_pkg::ALU_RL);
        add_widths(alu_pkg::ALU_RL);
        add_widths(alu_pkg::ALU_RR);
        add_widths(alu_pkg::ALU_RR);
        add_widths(alu_pkg::ALU_MOVE);
        // idle rows, cen low first so alu_we still holds the long width
        add_row(alu_pkg::ALU_ADD, W_L, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        add_row(alu_pkg::ALU_ADD, W_IDLE, 1'b0, 1'b1, 1'b0, '0, '0, '0);
        add_row(alu_pkg::ALU_XOR, W_IDLE, 1'b1, 1'b1, 1'b0, '0, '0, '0);
    endtask

    initial begin
        int limit_ns;
        wait (table_done);
        limit_ns = 2 * rows.size() * 2 * CLK_NS + RST_CYCLES * CLK_NS;
        #(limit_ns);
        fail_run("timeout: the table did not finish in the expected time");
    end

    initial begin
        row_t           t;
        alu_pkg::word_t op2;
        clk        = 1'b0;
        rst        = 1'b1;
        cen        = 1'b0;
        op0        = '0;
        op1        = '0;
        imm        = '0;
        sel_imm    = 1'b0;
        sel        = alu_pkg::ALU_MOVE;
        w          = W_IDLE;
        lcg_state  = 32'd62;
        table_done = 1'b0;
        cur_row    = -1;
        ref_dout   = '0;
        ref_mask   = '1;
        ref_flags  = '0;
        ref_we     = W_IDLE;
        build_table();
        table_done = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("dout", dout, '0);
        check_flags("flags", flags, '0);
        check_width("alu_we", alu_we, '0);

        for (int i = 0; i < rows.size(); i++) begin
            cur_row = i;
            t = rows[i];
            if (!t.fixed) begin
                t.op0 = rand_word();
                t.op1 = rand_word();
                t.imm = rand_word();
            end
            op2 = t.sel_imm ? t.imm : t.op1;
            @(posedge clk);
            cen     <= t.cen;
            w       <= t.w;
            sel     <= t.op;
            sel_imm <= t.sel_imm;
            op0     <= t.op0;
            op1     <= t.op1;
            imm     <= t.imm;
            if (t.cen) begin
                ref_we = t.w;
                if (t.w != W_IDLE)
                    apply_model(t.op, t.w, t.op0, op2);
            end
            @(posedge clk);     // row captured here
            cen <= 1'b0;
            w   <= W_IDLE;
            @(negedge clk);
            check_word("dout", dout & ref_mask, ref_dout & ref_mask);
            check_flags("flags", flags, ref_flags);
            check_width("alu_we", alu_we, ref_we);
            if (t.fixed)
                check_word("dout vs table", dout & width_mask(t.w), t.exp);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
alu_pkg.sv
alu_unit_if.sv
alu_adder.sv
alu_logic.sv
alu_shifter.sv
alu_writeback.sv
alu_top.sv
tb_alu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST) $(VFLAGS)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
